//--- run_sim.sh
#!/bin/sh
# Build and run the VALU testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f valu_top.f --top-module valu_tb -o valu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/valu_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
    exit 0
fi
exit 1

//--- source/valu_arith.sv
`timescale 1ns/10ps
`default_nettype none

module valu_arith (
    input  logic                          clk,
    input  logic                          rst,
    valu_exec_if.unit                     exec,
    output logic                          result_valid,
    output logic [valu_pkg::DATA_W-1:0]   result_data
);
    import valu_pkg::*;

    vec_word_t       op_a, op_b;
    vec_word_t       add_x, add_y;
    vec_word_t       sum_c;
    logic [BE_W-1:0] lt_c;
    logic            is_sub, is_rsub, is_signed, is_minmax, is_max;

    logic            s1_valid;
    vec_word_t       s1_sum, s1_a, s1_b;
    logic [BE_W-1:0] s1_lt;   // One flag per lane, low lanes used at wide SEW
    logic [SEW_W-1:0] s1_sew;
    logic            s1_minmax, s1_max;
    vec_word_t       word_c;

    assign op_a = exec.data0;
    assign op_b = exec.data1;

    assign is_rsub   = (exec.func == FN_RSUB);
    assign is_sub    = (exec.func == FN_SUB) | is_rsub;
    assign is_signed = (exec.func == FN_MIN) | (exec.func == FN_MAX);
    assign is_max    = (exec.func == FN_MAX) | (exec.func == FN_MAXU);
    assign is_minmax = (exec.func == FN_MIN) | (exec.func == FN_MINU) | is_max;

    // sub is data0 - data1, rsub is data1 - data0
    assign add_x = is_rsub ? op_b : op_a;
    assign add_y = is_rsub ? op_a : op_b;

    always_comb begin
        sum_c = '0;
        lt_c  = '0;
        case (exec.sew)
            SEW_8: begin
                for (int i = 0; i < DATA_W / 8; i++) begin
                    sum_c.b[i] = is_sub ? add_x.b[i] - add_y.b[i] : add_x.b[i] + add_y.b[i];
                    lt_c[i] = is_signed ? ($signed(op_a.b[i]) < $signed(op_b.b[i]))
                                        : (op_a.b[i] < op_b.b[i]);
                end
            end
            SEW_16: begin
                for (int i = 0; i < DATA_W / 16; i++) begin
                    sum_c.h[i] = is_sub ? add_x.h[i] - add_y.h[i] : add_x.h[i] + add_y.h[i];
                    lt_c[i] = is_signed ? ($signed(op_a.h[i]) < $signed(op_b.h[i]))
                                        : (op_a.h[i] < op_b.h[i]);
                end
            end
            SEW_32: begin
                for (int i = 0; i < DATA_W / 32; i++) begin
                    sum_c.w[i] = is_sub ? add_x.w[i] - add_y.w[i] : add_x.w[i] + add_y.w[i];
                    lt_c[i] = is_signed ? ($signed(op_a.w[i]) < $signed(op_b.w[i]))
                                        : (op_a.w[i] < op_b.w[i]);
                end
            end
            SEW_64: begin
                sum_c.d = is_sub ? add_x.d - add_y.d : add_x.d + add_y.d;
                lt_c[0] = is_signed ? ($signed(op_a.d) < $signed(op_b.d)) : (op_a.d < op_b.d);
            end
            default: begin
                sum_c = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= exec.arith_valid;
        end
        if (exec.arith_valid) begin
            s1_sum    <= sum_c;
            s1_lt     <= lt_c;
            s1_a      <= op_a;
            s1_b      <= op_b;
            s1_sew    <= exec.sew;
            s1_minmax <= is_minmax;
            s1_max    <= is_max;
        end
    end

    // Byte i belongs to lane i >> sew
    always_comb begin
        word_c = s1_sum;
        for (int i = 0; i < BE_W; i++) begin
            if (s1_minmax) begin
                word_c.b[i] = (s1_lt[i >> s1_sew] ^ s1_max) ? s1_a.b[i] : s1_b.b[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            result_data  <= '0;
        end else begin
            result_valid <= s1_valid;
            result_data  <= s1_valid ? word_c.d : '0; // Zero when idle, ORed downstream
        end
    end

endmodule

`default_nettype wire

//--- source/valu_decode.sv
`timescale 1ns/10ps
`default_nettype none

module valu_decode (
    input  logic                          req_valid,
    input  logic [valu_pkg::FUNC_W-1:0]   req_func_id,
    input  logic [valu_pkg::SEW_W-1:0]    req_sew,
    input  logic [valu_pkg::DATA_W-1:0]   req_data0,
    input  logic [valu_pkg::DATA_W-1:0]   req_data1,
    input  logic [valu_pkg::BE_W-1:0]     req_be,
    valu_exec_if.decode                   exec,
    output logic                          accepted
);
    import valu_pkg::*;

    logic is_arith;
    logic is_logic;

    always_comb begin
        is_arith = 1'b0;
        is_logic = 1'b0;
        case (req_func_id)
            FN_ADD, FN_SUB, FN_RSUB,
            FN_MINU, FN_MIN, FN_MAXU, FN_MAX: begin
                is_arith = 1'b1;
            end
            FN_AND, FN_OR, FN_XOR, FN_MERGE: begin
                is_logic = 1'b1;
            end
            default: begin
                // Unknown code, dropped silently
                is_arith = 1'b0;
                is_logic = 1'b0;
            end
        endcase
    end

    assign exec.arith_valid = req_valid & is_arith;
    assign exec.logic_valid = req_valid & is_logic;

    // Operands pass straight through
    assign exec.func  = req_func_id;
    assign exec.sew   = req_sew;
    assign exec.data0 = req_data0;
    assign exec.data1 = req_data1;
    assign exec.be    = req_be;

    assign accepted = req_valid & (is_arith | is_logic);

endmodule

`default_nettype wire

//--- source/valu_exec_if.sv
`timescale 1ns/10ps
`default_nettype none

interface valu_exec_if;
    import valu_pkg::*;

    logic              arith_valid;
    logic              logic_valid;
    logic [FUNC_W-1:0] func;
    logic [SEW_W-1:0]  sew;
    logic [DATA_W-1:0] data0;
    logic [DATA_W-1:0] data1;
    logic [BE_W-1:0]   be;

    modport decode (output arith_valid, logic_valid, func, sew, data0, data1, be);
    modport unit   (input arith_valid, logic_valid, func, sew, data0, data1, be);

endinterface

`default_nettype wire

//--- source/valu_logic.sv
`timescale 1ns/10ps
`default_nettype none

module valu_logic (
    input  logic                          clk,
    input  logic                          rst,
    valu_exec_if.unit                     exec,
    output logic                          result_valid,
    output logic [valu_pkg::DATA_W-1:0]   result_data
);
    import valu_pkg::*;

    logic [DATA_W-1:0] logic_c;
    logic [DATA_W-1:0] s1_data;
    logic              s1_valid;

    always_comb begin
        case (exec.func)
            FN_AND: logic_c = exec.data0 & exec.data1;
            FN_OR:  logic_c = exec.data0 | exec.data1;
            FN_XOR: logic_c = exec.data0 ^ exec.data1;
            default: begin
                // Merge, byte from data0 where be set
                for (int i = 0; i < BE_W; i++) begin
                    logic_c[8*i +: 8] = exec.be[i] ? exec.data0[8*i +: 8] : exec.data1[8*i +: 8];
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid     <= 1'b0;
            result_valid <= 1'b0;
            result_data  <= '0;
        end else begin
            s1_valid     <= exec.logic_valid;
            result_valid <= s1_valid;
            result_data  <= s1_valid ? s1_data : '0;
        end
        if (exec.logic_valid) s1_data <= logic_c;
    end

endmodule

`default_nettype wire

//--- source/valu_pkg.sv
`default_nettype none

package valu_pkg;

    // Datapath and sideband widths
    localparam int DATA_W = 64;
    localparam int BE_W   = DATA_W / 8;
    localparam int ADDR_W = 32;
    localparam int VL_W   = 8;
    localparam int OFF_W  = 8;
    localparam int FUNC_W = 6;
    localparam int SEW_W  = 2;

    localparam int UNIT_LATENCY = 2; // Register stages per unit
    localparam int VALU_LATENCY = 3; // Unit stages plus response register

    localparam logic [SEW_W-1:0] SEW_8  = 2'd0;
    localparam logic [SEW_W-1:0] SEW_16 = 2'd1;
    localparam logic [SEW_W-1:0] SEW_32 = 2'd2;
    localparam logic [SEW_W-1:0] SEW_64 = 2'd3;

    // Arithmetic group
    localparam logic [FUNC_W-1:0] FN_ADD  = 6'b000000;
    localparam logic [FUNC_W-1:0] FN_SUB  = 6'b000010;
    localparam logic [FUNC_W-1:0] FN_RSUB = 6'b000011;
    localparam logic [FUNC_W-1:0] FN_MINU = 6'b000100;
    localparam logic [FUNC_W-1:0] FN_MIN  = 6'b000101;
    localparam logic [FUNC_W-1:0] FN_MAXU = 6'b000110;
    localparam logic [FUNC_W-1:0] FN_MAX  = 6'b000111;

    // Logic group
    localparam logic [FUNC_W-1:0] FN_AND   = 6'b001001;
    localparam logic [FUNC_W-1:0] FN_OR    = 6'b001010;
    localparam logic [FUNC_W-1:0] FN_XOR   = 6'b001011;
    localparam logic [FUNC_W-1:0] FN_MERGE = 6'b010111;

    // One register chunk seen as lanes of each element width
    typedef union packed {
        logic [DATA_W/8-1:0][7:0]   b;
        logic [DATA_W/16-1:0][15:0] h;
        logic [DATA_W/32-1:0][31:0] w;
        logic [DATA_W-1:0]          d;
    } vec_word_t;

endpackage

`default_nettype wire

//--- source/valu_response.sv
`timescale 1ns/10ps
`default_nettype none

module valu_response (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          accepted,
    input  logic [valu_pkg::ADDR_W-1:0]   req_addr,
    input  logic [valu_pkg::BE_W-1:0]     req_be,
    input  logic [valu_pkg::VL_W-1:0]     req_vl,
    input  logic [valu_pkg::OFF_W-1:0]    req_off,
    input  logic                          req_start,
    input  logic                          req_end,
    input  logic                          arith_valid,
    input  logic [valu_pkg::DATA_W-1:0]   arith_data,
    input  logic                          logic_valid,
    input  logic [valu_pkg::DATA_W-1:0]   logic_data,
    output logic                          resp_valid,
    output logic [valu_pkg::DATA_W-1:0]   resp_data,
    output logic [valu_pkg::ADDR_W-1:0]   resp_addr,
    output logic [valu_pkg::BE_W-1:0]     resp_be,
    output logic [valu_pkg::VL_W-1:0]     resp_vl,
    output logic [valu_pkg::OFF_W-1:0]    resp_off,
    output logic                          resp_start,
    output logic                          resp_end
);
    import valu_pkg::*;

    // addr, be, vl, off, start, end
    logic [ADDR_W+BE_W+VL_W+OFF_W+1:0] sb_in;
    logic [ADDR_W+BE_W+VL_W+OFF_W+1:0] sb_q [UNIT_LATENCY];
    logic                              unit_valid;

    assign sb_in = accepted ? {req_addr, req_be, req_vl, req_off, req_start, req_end} : '0;
    assign unit_valid = arith_valid | logic_valid;

    // Sideband delay line matching the unit pipelines
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < UNIT_LATENCY; i++) sb_q[i] <= '0;
        end else begin
            sb_q[0] <= sb_in;
            for (int i = 1; i < UNIT_LATENCY; i++) sb_q[i] <= sb_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
            resp_data  <= '0;
            {resp_addr, resp_be, resp_vl, resp_off, resp_start, resp_end} <= '0;
        end else begin
            resp_valid <= unit_valid;
            resp_data  <= arith_data | logic_data; // Idle units drive zero
            {resp_addr, resp_be, resp_vl, resp_off, resp_start, resp_end} <=
                unit_valid ? sb_q[UNIT_LATENCY-1] : '0;
        end
    end

endmodule

`default_nettype wire

//--- source/valu_top.sv
`timescale 1ns/10ps
`default_nettype none

module valu_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  logic [valu_pkg::FUNC_W-1:0]   req_func_id,
    input  logic [valu_pkg::SEW_W-1:0]    req_sew,
    input  logic [valu_pkg::DATA_W-1:0]   req_data0,
    input  logic [valu_pkg::DATA_W-1:0]   req_data1,
    input  logic [valu_pkg::ADDR_W-1:0]   req_addr,
    input  logic [valu_pkg::BE_W-1:0]     req_be,
    input  logic [valu_pkg::VL_W-1:0]     req_vl,
    input  logic                          req_start,
    input  logic                          req_end,
    input  logic [valu_pkg::OFF_W-1:0]    req_off,
    output logic                          resp_valid,
    output logic [valu_pkg::DATA_W-1:0]   resp_data,
    output logic [valu_pkg::ADDR_W-1:0]   resp_addr,
    output logic [valu_pkg::BE_W-1:0]     resp_be,
    output logic [valu_pkg::VL_W-1:0]     resp_vl,
    output logic [valu_pkg::OFF_W-1:0]    resp_off,
    output logic                          resp_start,
    output logic                          resp_end
);
    import valu_pkg::*;

    logic              accepted;
    logic              arith_valid, logic_valid;
    logic [DATA_W-1:0] arith_data, logic_data;

    valu_exec_if exec_if ();

    valu_decode valu_decode_inst (
        .req_valid   (req_valid),
        .req_func_id (req_func_id),
        .req_sew     (req_sew),
        .req_data0   (req_data0),
        .req_data1   (req_data1),
        .req_be      (req_be),
        .exec        (exec_if.decode),
        .accepted    (accepted)
    );

    valu_arith valu_arith_inst (
        .clk          (clk),
        .rst          (rst),
        .exec         (exec_if.unit),
        .result_valid (arith_valid),
        .result_data  (arith_data)
    );

    valu_logic valu_logic_inst (
        .clk          (clk),
        .rst          (rst),
        .exec         (exec_if.unit),
        .result_valid (logic_valid),
        .result_data  (logic_data)
    );

    valu_response valu_response_inst (
        .clk         (clk),
        .rst         (rst),
        .accepted    (accepted),
        .req_addr    (req_addr),
        .req_be      (req_be),
        .req_vl      (req_vl),
        .req_off     (req_off),
        .req_start   (req_start),
        .req_end     (req_end),
        .arith_valid (arith_valid),
        .arith_data  (arith_data),
        .logic_valid (logic_valid),
        .logic_data  (logic_data),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_addr   (resp_addr),
        .resp_be     (resp_be),
        .resp_vl     (resp_vl),
        .resp_off    (resp_off),
        .resp_start  (resp_start),
        .resp_end    (resp_end)
    );

endmodule

`default_nettype wire

//--- tb/valu_properties.sv
`timescale 1ns/10ps
`default_nettype none

module valu_properties (
    input logic                          clk,
    input logic                          rst,
    input logic                          req_valid,
    input logic [valu_pkg::FUNC_W-1:0]   req_func_id,
    input logic [valu_pkg::SEW_W-1:0]    req_sew,
    input logic [valu_pkg::DATA_W-1:0]   req_data0,
    input logic [valu_pkg::DATA_W-1:0]   req_data1,
    input logic [valu_pkg::ADDR_W-1:0]   req_addr,
    input logic [valu_pkg::BE_W-1:0]     req_be,
    input logic [valu_pkg::VL_W-1:0]     req_vl,
    input logic                          req_start,
    input logic                          req_end,
    input logic [valu_pkg::OFF_W-1:0]    req_off,
    input logic                          resp_valid,
    input logic [valu_pkg::DATA_W-1:0]   resp_data,
    input logic [valu_pkg::ADDR_W-1:0]   resp_addr,
    input logic [valu_pkg::BE_W-1:0]     resp_be,
    input logic [valu_pkg::VL_W-1:0]     resp_vl,
    input logic [valu_pkg::OFF_W-1:0]    resp_off,
    input logic                          resp_start,
    input logic                          resp_end
);
    import valu_pkg::*;

    localparam int RESP_W = 1 + DATA_W + ADDR_W + BE_W + VL_W + OFF_W + 2;

    int                err_cnt [8] = '{default: 0}; // valid data addr be vl off start end
    logic [RESP_W-1:0] exp_in;
    logic [RESP_W-1:0] exp_q [VALU_LATENCY];
    logic              exp_valid, exp_start, exp_end;
    logic [DATA_W-1:0] exp_data;
    logic [ADDR_W-1:0] exp_addr;
    logic [BE_W-1:0]   exp_be;
    logic [VL_W-1:0]   exp_vl;
    logic [OFF_W-1:0]  exp_off;

    // One lane of width w, operands zero extended
    function automatic logic [63:0] lane_op(input logic [FUNC_W-1:0] func,
                                            input logic [63:0] a, input logic [63:0] b,
                                            input int w);
        logic [63:0] mask;
        logic [63:0] sign;
        mask = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
        sign = 64'd1 << (w - 1);
        case (func)
            FN_ADD:  return (a + b) & mask;
            FN_SUB:  return (a - b) & mask;
            FN_RSUB: return (b - a) & mask;
            FN_MINU: return (a < b) ? a : b;
            FN_MAXU: return (a < b) ? b : a;
            FN_MIN:  return ((a ^ sign) < (b ^ sign)) ? a : b; // Bias flips signed order
            default: return ((a ^ sign) < (b ^ sign)) ? b : a;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] expected_word(input logic [FUNC_W-1:0] func,
                                                        input logic [SEW_W-1:0] sew,
                                                        input vec_word_t a, input vec_word_t b,
                                                        input logic [BE_W-1:0] be);
        vec_word_t r;
        r = '0;
        case (func)
            FN_AND: r.d = a.d & b.d;
            FN_OR:  r.d = a.d | b.d;
            FN_XOR: r.d = a.d ^ b.d;
            FN_MERGE: begin
                for (int i = 0; i < BE_W; i++) begin
                    r.b[i] = be[i] ? a.b[i] : b.b[i];
                end
            end
            default: begin
                case (sew)
                    SEW_8: begin
                        for (int i = 0; i < 8; i++) begin
                            r.b[i] = 8'(lane_op(func, 64'(a.b[i]), 64'(b.b[i]), 8));
                        end
                    end
                    SEW_16: begin
                        for (int i = 0; i < 4; i++) begin
                            r.h[i] = 16'(lane_op(func, 64'(a.h[i]), 64'(b.h[i]), 16));
                        end
                    end
                    SEW_32: begin
                        for (int i = 0; i < 2; i++) begin
                            r.w[i] = 32'(lane_op(func, 64'(a.w[i]), 64'(b.w[i]), 32));
                        end
                    end
                    default: r.d = lane_op(func, a.d, b.d, 64);
                endcase
            end
        endcase
        return r.d;
    endfunction

    assign exp_in = (req_valid && (req_func_id inside {FN_ADD, FN_SUB, FN_RSUB, FN_MINU,
                     FN_MIN, FN_MAXU, FN_MAX, FN_AND, FN_OR, FN_XOR, FN_MERGE}))
                  ? {1'b1, expected_word(req_func_id, req_sew, req_data0, req_data1, req_be),
                     req_addr, req_be, req_vl, req_off, req_start, req_end}
                  : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < VALU_LATENCY; i++) exp_q[i] <= '0;
        end else begin
            exp_q[0] <= exp_in;
            for (int i = 1; i < VALU_LATENCY; i++) exp_q[i] <= exp_q[i-1];
        end
    end

    assign {exp_valid, exp_data, exp_addr, exp_be, exp_vl, exp_off, exp_start, exp_end} =
        exp_q[VALU_LATENCY-1];

    a_valid: assert property (@(posedge clk) disable iff (rst) resp_valid == exp_valid)
        else begin
            err_cnt[0]++;
            $error("** Error at %0t: resp_valid expected %h, got %h", $time,
                   $sampled(exp_valid), $sampled(resp_valid));
        end
    a_data: assert property (@(posedge clk) disable iff (rst) resp_data == exp_data)
        else begin
            err_cnt[1]++;
            $error("** Error at %0t: resp_data expected %h, got %h", $time,
                   $sampled(exp_data), $sampled(resp_data));
        end
    a_addr: assert property (@(posedge clk) disable iff (rst) resp_addr == exp_addr)
        else begin
            err_cnt[2]++;
            $error("** Error at %0t: resp_addr expected %h, got %h", $time,
                   $sampled(exp_addr), $sampled(resp_addr));
        end
    a_be: assert property (@(posedge clk) disable iff (rst) resp_be == exp_be)
        else begin
            err_cnt[3]++;
            $error("** Error at %0t: resp_be expected %h, got %h", $time,
                   $sampled(exp_be), $sampled(resp_be));
        end
    a_vl: assert property (@(posedge clk) disable iff (rst) resp_vl == exp_vl)
        else begin
            err_cnt[4]++;
            $error("** Error at %0t: resp_vl expected %h, got %h", $time,
                   $sampled(exp_vl), $sampled(resp_vl));
        end
    a_off: assert property (@(posedge clk) disable iff (rst) resp_off == exp_off)
        else begin
            err_cnt[5]++;
            $error("** Error at %0t: resp_off expected %h, got %h", $time,
                   $sampled(exp_off), $sampled(resp_off));
        end
    a_start: assert property (@(posedge clk) disable iff (rst) resp_start == exp_start)
        else begin
            err_cnt[6]++;
            $error("** Error at %0t: resp_start expected %h, got %h", $time,
                   $sampled(exp_start), $sampled(resp_start));
        end
    a_end: assert property (@(posedge clk) disable iff (rst) resp_end == exp_end)
        else begin
            err_cnt[7]++;
            $error("** Error at %0t: resp_end expected %h, got %h", $time,
                   $sampled(exp_end), $sampled(resp_end));
        end

endmodule

`default_nettype wire

//--- tb/valu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module valu_tb;
    import valu_pkg::*;

    localparam int ARITH_REQS  = 84; // 7 functions, 4 widths, 3 each
    localparam int LOGIC_REQS  = 24;
    localparam int BAD_REQS    = 8;
    localparam int IDLE_CYCLES = 13;
    localparam int CYCLE_LIMIT = 8 + ARITH_REQS + LOGIC_REQS + BAD_REQS + IDLE_CYCLES
                               + VALU_LATENCY + 20;

    logic              clk = 1'b0;
    logic              rst;
    logic              req_valid, req_start, req_end;
    logic [FUNC_W-1:0] req_func_id;
    logic [SEW_W-1:0]  req_sew;
    logic [DATA_W-1:0] req_data0, req_data1;
    logic [ADDR_W-1:0] req_addr;
    logic [BE_W-1:0]   req_be;
    logic [VL_W-1:0]   req_vl;
    logic [OFF_W-1:0]  req_off;
    logic              resp_valid, resp_start, resp_end;
    logic [DATA_W-1:0] resp_data;
    logic [ADDR_W-1:0] resp_addr;
    logic [BE_W-1:0]   resp_be;
    logic [VL_W-1:0]   resp_vl;
    logic [OFF_W-1:0]  resp_off;
    int                cycles = 0;
    int                errors = 0;

    logic [FUNC_W-1:0] arith_fn [7] = '{FN_ADD, FN_SUB, FN_RSUB, FN_MINU, FN_MIN, FN_MAXU, FN_MAX};
    logic [FUNC_W-1:0] logic_fn [4] = '{FN_AND, FN_OR, FN_XOR, FN_MERGE};
    logic [FUNC_W-1:0] bad_fn [4]   = '{6'b000001, 6'b001000, 6'b011111, 6'b111111};

    always #10 clk = ~clk;

    valu_top valu_top_inst (.*);

    bind valu_top valu_properties valu_properties_inst (.*);

    function automatic logic [DATA_W-1:0] rand_word();
        return {$urandom, $urandom};
    endfunction

    // Top bit of every lane at this width
    function automatic logic [DATA_W-1:0] lane_sign_bits(input int sew);
        logic [DATA_W-1:0] m;
        m = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (i % (8 << sew) == (8 << sew) - 1) m[i] = 1'b1;
        end
        return m;
    endfunction

    task automatic send(input logic valid, input logic [FUNC_W-1:0] func,
                        input logic [SEW_W-1:0] sew, input logic [DATA_W-1:0] d0,
                        input logic [DATA_W-1:0] d1);
        @(posedge clk);
        req_valid   <= valid;
        req_func_id <= func;
        req_sew     <= sew;
        req_data0   <= d0;
        req_data1   <= d1;
        req_addr    <= $urandom;
        req_be      <= BE_W'($urandom);
        req_vl      <= VL_W'($urandom);
        req_off     <= OFF_W'($urandom);
        req_start   <= 1'($urandom);
        req_end     <= 1'($urandom);
    endtask

    task automatic idle(input int n);
        repeat (n) send(1'b0, FN_ADD, SEW_W'($urandom), rand_word(), rand_word());
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        logic [DATA_W-1:0] d0;
        logic [DATA_W-1:0] d1;
        void'($urandom(32'hd9da));
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_func_id = '0;
        req_sew     = '0;
        req_data0   = '0;
        req_data1   = '0;
        req_addr    = '0;
        req_be      = '0;
        req_vl      = '0;
        req_off     = '0;
        req_start   = 1'b0;
        req_end     = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        idle(4);
        for (int f = 0; f < 7; f++) begin
            for (int s = 0; s < 4; s++) begin
                for (int r = 0; r < 3; r++) begin
                    d0 = rand_word();
                    d1 = rand_word();
                    if (r == 0) begin
                        d0 = d0 | lane_sign_bits(s); // Negative lanes in data0 only
                        d1 = d1 & ~lane_sign_bits(s);
                    end else if (r == 1) begin
                        d0 = d0 & ~lane_sign_bits(s); // Negative lanes in data1 only
                        d1 = d1 | lane_sign_bits(s);
                    end
                    send(1'b1, arith_fn[f], SEW_W'(s), d0, d1);
                end
            end
        end
        idle(4);
        for (int i = 0; i < LOGIC_REQS; i++) begin
            send(1'b1, logic_fn[i % 4], SEW_W'($urandom), rand_word(), rand_word());
        end
        idle(4);
        for (int i = 0; i < BAD_REQS; i++) begin
            send(1'b1, bad_fn[i % 4], SEW_W'($urandom), rand_word(), rand_word());
        end
        idle(1);
        repeat (VALU_LATENCY + 1) @(posedge clk);

        for (int i = 0; i < 8; i++) errors += valu_top_inst.valu_properties_inst.err_cnt[i];
        $display("Errors: valid %0d data %0d addr %0d be %0d vl %0d off %0d start %0d end %0d",
                 valu_top_inst.valu_properties_inst.err_cnt[0],
                 valu_top_inst.valu_properties_inst.err_cnt[1],
                 valu_top_inst.valu_properties_inst.err_cnt[2],
                 valu_top_inst.valu_properties_inst.err_cnt[3],
                 valu_top_inst.valu_properties_inst.err_cnt[4],
                 valu_top_inst.valu_properties_inst.err_cnt[5],
                 valu_top_inst.valu_properties_inst.err_cnt[6],
                 valu_top_inst.valu_properties_inst.err_cnt[7]);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- valu_top.f
source/valu_pkg.sv
source/valu_exec_if.sv
source/valu_decode.sv
source/valu_arith.sv
source/valu_logic.sv
source/valu_response.sv
source/valu_top.sv
tb/valu_properties.sv
tb/valu_tb.sv
